//--- build.f
hw/retire_pkg.sv
hw/stage_reg.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/cp0_regs.sv
hw/regfile.sv
hw/retire_top.sv
verification/retire_assertions.sv
verification/retire_tb.sv

//--- hw/cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regs
    import retire_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire cp0_req_t req,
    input  wire [5:0]     ext_int,
    output logic [31:0]   rdata,
    output logic [31:0]   epc,
    output logic          status_ie,
    output logic          status_exl,
    output logic [7:0]    status_im,
    output logic [7:0]    cause_ip,
    output logic          cause_ti
);

    logic        wr_en;
    logic        ex_take;
    logic        eret_take;
    logic        ex_log;         // exception recorded only outside exception level
    logic [5:0]  ip_hw;
    logic [1:0]  ip_sw;
    logic        cause_bd;
    logic [4:0]  cause_exc;
    logic [31:0] badvaddr;
    logic [31:0] count;
    logic [31:0] compare;
    logic        count_tick;

    assign ex_take   = req.valid & req.ex;
    assign eret_take = req.valid & req.eret & ~req.ex;
    assign wr_en     = req.valid & req.mtc0 & ~req.ex & (req.sel == 3'd0);
    assign ex_log    = ex_take & ~status_exl;

    assign cause_ip = {ip_hw[5] | cause_ti, ip_hw[4:0], ip_sw};   // timer shares ip7

    always_ff @(posedge clk) begin
        if (reset) begin
            status_ie  <= 1'b0;
            status_exl <= 1'b1;
            status_im  <= 8'd0;
        end else if (ex_take) begin
            status_exl <= 1'b1;
        end else if (eret_take) begin
            status_exl <= 1'b0;
        end else if (wr_en && req.rd == CP0_STATUS) begin
            status_im  <= req.wdata[15:8];
            status_exl <= req.wdata[1];
            status_ie  <= req.wdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ip_hw     <= 6'd0;
            ip_sw     <= 2'd0;
            cause_bd  <= 1'b0;
            cause_exc <= 5'd0;
        end else begin
            ip_hw <= ext_int;            // sampled every cycle
            if (ex_log) begin
                cause_bd  <= req.bd;
                cause_exc <= req.exc_code;
            end else if (wr_en && req.rd == CP0_CAUSE) begin
                ip_sw <= req.wdata[9:8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_log) begin
            epc <= req.bd ? req.pc - 32'd4 : req.pc;   // restart at the branch
        end else if (wr_en && req.rd == CP0_EPC) begin
            epc <= req.wdata;
        end
        if (ex_log && req.exc_code == EXC_ADEL) begin
            badvaddr <= req.badvaddr;
        end
    end

    // count runs at half the core clock
    always_ff @(posedge clk) begin
        if (reset) begin
            count_tick <= 1'b0;
            count      <= 32'd0;
            compare    <= 32'd0;
            cause_ti   <= 1'b0;
        end else begin
            count_tick <= ~count_tick;
            if (wr_en && req.rd == CP0_COUNT) begin
                count <= req.wdata;
            end else if (count_tick) begin
                count <= count + 32'd1;
            end
            if (wr_en && req.rd == CP0_COMPARE) begin
                compare  <= req.wdata;
                cause_ti <= 1'b0;        // acknowledge the timer
            end else if (count == compare) begin
                cause_ti <= 1'b1;
            end
        end
    end

    always_comb begin
        rdata = 32'd0;
        if (req.sel == 3'd0) begin
            case (req.rd)
                CP0_BADVADDR: rdata = badvaddr;
                CP0_COUNT:    rdata = count;
                CP0_COMPARE:  rdata = compare;
                CP0_STATUS:   rdata = {9'd0, 1'b1, 6'd0, status_im, 6'd0, status_exl, status_ie};
                CP0_CAUSE:    rdata = {cause_bd, cause_ti, 14'd0, cause_ip, 1'b0, cause_exc, 2'd0};
                CP0_EPC:      rdata = epc;
                default:      rdata = 32'd0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import retire_pkg::*;
(
    input  wire            in_valid,
    input  wire ex_to_ms_t in_bus,
    output logic           out_valid,
    output ms_to_ws_t      out_bus
);

    logic [1:0]  addr_lo;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] load_data;
    logic        adel;

    assign addr_lo  = in_bus.alu_result[1:0];
    assign byte_sel = in_bus.load_word[{addr_lo, 3'b000} +: 8];   // little endian lanes
    assign half_sel = addr_lo[1] ? in_bus.load_word[31:16] : in_bus.load_word[15:0];

    always_comb begin
        case (in_bus.load_op)
            ld_lb: begin
                load_data = {{24{byte_sel[7]}}, byte_sel};
            end
            ld_lbu: begin
                load_data = {24'd0, byte_sel};
            end
            ld_lh: begin
                load_data = {{16{half_sel[15]}}, half_sel};
            end
            ld_lhu: begin
                load_data = {16'd0, half_sel};
            end
            ld_lw: begin
                load_data = in_bus.load_word;
            end
            default: begin
                load_data = in_bus.alu_result;   // not a load
            end
        endcase
    end

    // halfword needs bit 0 clear, word needs both low bits clear
    always_comb begin
        adel = 1'b0;
        if ((in_bus.load_op == ld_lh || in_bus.load_op == ld_lhu) && addr_lo[0]) begin
            adel = 1'b1;
        end
        if (in_bus.load_op == ld_lw && addr_lo != 2'b00) begin
            adel = 1'b1;
        end
    end

    assign out_valid = in_valid;

    always_comb begin
        out_bus.pc       = in_bus.pc;
        out_bus.gr_we    = in_bus.gr_we;
        out_bus.dest     = in_bus.dest;
        out_bus.mtc0     = in_bus.mtc0;
        out_bus.mfc0     = in_bus.mfc0;
        out_bus.eret     = in_bus.eret;
        out_bus.cp0_rd   = in_bus.cp0_rd;
        out_bus.cp0_sel  = in_bus.cp0_sel;
        out_bus.bd       = in_bus.bd;
        out_bus.ex       = in_bus.ex_in | adel;
        out_bus.exc_code = in_bus.ex_in ? in_bus.exc_code_in : EXC_ADEL;   // older one wins
        // an excepting instruction never writes, so result carries the bad address
        out_bus.result   = out_bus.ex ? in_bus.alu_result : load_data;
    end

endmodule

`default_nettype wire

//--- hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile
    import retire_pkg::*;
(
    input  wire            clk,
    input  wire rf_write_t write,
    input  wire [4:0]      raddr1,
    input  wire [4:0]      raddr2,
    output logic [31:0]    rdata1,
    output logic [31:0]    rdata2
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (write.we && write.waddr != 5'd0) begin
            regs[write.waddr] <= write.wdata;
        end
    end

    // $zero is hardwired, entry 0 never gets written
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire

//--- hw/retire_pkg.sv
`default_nettype none

package retire_pkg;

    // cp0 register numbers, select 0
    localparam logic [4:0] CP0_BADVADDR = 5'd8;
    localparam logic [4:0] CP0_COUNT    = 5'd9;
    localparam logic [4:0] CP0_COMPARE  = 5'd11;
    localparam logic [4:0] CP0_STATUS   = 5'd12;
    localparam logic [4:0] CP0_CAUSE    = 5'd13;
    localparam logic [4:0] CP0_EPC      = 5'd14;

    localparam logic [4:0] EXC_INT  = 5'd0;   // interrupt
    localparam logic [4:0] EXC_ADEL = 5'd4;   // load address error
    localparam logic [4:0] EXC_SYS  = 5'd8;   // syscall

    localparam logic [31:0] EXC_VECTOR = 32'hbfc0_0380;   // bev=1 general vector

    typedef enum logic [2:0] {
        ld_none = 3'd0,
        ld_lb   = 3'd1,
        ld_lbu  = 3'd2,
        ld_lh   = 3'd3,
        ld_lhu  = 3'd4,
        ld_lw   = 3'd5
    } load_op_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_result;    // also the load address
        logic [31:0] load_word;     // word already fetched by execute
        load_op_t    load_op;
        logic        gr_we;
        logic [4:0]  dest;
        logic        mtc0;
        logic        mfc0;
        logic        eret;
        logic [4:0]  cp0_rd;
        logic [2:0]  cp0_sel;
        logic        bd;            // in a branch delay slot
        logic        ex_in;         // exception raised upstream
        logic [4:0]  exc_code_in;
    } ex_to_ms_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;        // load address when ex is set
        logic        gr_we;
        logic [4:0]  dest;
        logic        mtc0;
        logic        mfc0;
        logic        eret;
        logic [4:0]  cp0_rd;
        logic [2:0]  cp0_sel;
        logic        bd;
        logic        ex;
        logic [4:0]  exc_code;
    } ms_to_ws_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } rf_write_t;

    typedef struct packed {
        logic        valid;
        logic        mtc0;
        logic        eret;
        logic        ex;
        logic [4:0]  exc_code;
        logic [4:0]  rd;
        logic [2:0]  sel;
        logic        bd;
        logic [31:0] pc;
        logic [31:0] wdata;
        logic [31:0] badvaddr;
    } cp0_req_t;

endpackage

`default_nettype wire

//--- hw/retire_top.sv
`timescale 1ns/1ps
`default_nettype none

module retire_top
    import retire_pkg::*;
(
    input  wire            clk,
    input  wire            reset,
    input  wire            ex_valid,
    input  wire ex_to_ms_t ex_bus,
    input  wire [5:0]      ext_int,
    input  wire [4:0]      rf_raddr1,
    input  wire [4:0]      rf_raddr2,
    output logic [31:0]    rf_rdata1,
    output logic [31:0]    rf_rdata2,
    output logic           flush,
    output logic [31:0]    flush_pc,
    output logic           status_ie,
    output logic           status_exl,
    output logic [7:0]     status_im,
    output logic [7:0]     cause_ip,
    output logic           cause_ti,
    output logic [31:0]    debug_wb_pc,
    output logic           debug_wb_rf_wen,
    output logic [4:0]     debug_wb_rf_wnum,
    output logic [31:0]    debug_wb_rf_wdata
);

    logic      ms_reg_valid;
    ex_to_ms_t ms_reg_bus;
    logic      ms_valid;
    ms_to_ws_t ms_bus;
    logic      ws_valid;
    ms_to_ws_t ws_bus;
    cp0_req_t  cp0_req;
    logic [31:0] cp0_rdata;
    logic [31:0] cp0_epc;
    rf_write_t rf_write;

    stage_reg #(.payload_t(ex_to_ms_t)) ms_reg (
        .clk(clk), .reset(reset), .flush(flush),
        .in_valid(ex_valid), .in_bus(ex_bus),
        .out_valid(ms_reg_valid), .out_bus(ms_reg_bus)
    );

    mem_stage u_mem_stage (
        .in_valid(ms_reg_valid), .in_bus(ms_reg_bus),
        .out_valid(ms_valid), .out_bus(ms_bus)
    );

    stage_reg #(.payload_t(ms_to_ws_t)) ws_reg (
        .clk(clk), .reset(reset), .flush(flush),
        .in_valid(ms_valid), .in_bus(ms_bus),
        .out_valid(ws_valid), .out_bus(ws_bus)
    );

    wb_stage u_wb_stage (
        .in_valid(ws_valid), .in_bus(ws_bus),
        .cp0_rdata(cp0_rdata), .epc(cp0_epc),
        .cp0_req(cp0_req), .rf_write(rf_write),
        .flush(flush), .flush_pc(flush_pc),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    cp0_regs u_cp0_regs (
        .clk(clk), .reset(reset), .req(cp0_req), .ext_int(ext_int),
        .rdata(cp0_rdata), .epc(cp0_epc),
        .status_ie(status_ie), .status_exl(status_exl), .status_im(status_im),
        .cause_ip(cause_ip), .cause_ti(cause_ti)
    );

    regfile u_regfile (
        .clk(clk), .write(rf_write),
        .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

endmodule

`default_nettype wire

//--- hw/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           reset,
    input  wire           flush,
    input  wire           in_valid,
    input  wire payload_t in_bus,
    output logic          out_valid,
    output payload_t      out_bus
);

    // no back-pressure, so the stage takes whatever arrives
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;          // kill the younger instruction
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_bus <= in_bus;
        end
    end

endmodule

`default_nettype wire

//--- hw/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage
    import retire_pkg::*;
(
    input  wire             in_valid,
    input  wire ms_to_ws_t  in_bus,
    input  wire [31:0]      cp0_rdata,
    input  wire [31:0]      epc,
    output cp0_req_t        cp0_req,
    output rf_write_t       rf_write,
    output logic            flush,
    output logic [31:0]     flush_pc,
    output logic [31:0]     debug_wb_pc,
    output logic            debug_wb_rf_wen,
    output logic [4:0]      debug_wb_rf_wnum,
    output logic [31:0]     debug_wb_rf_wdata
);

    logic [31:0] final_result;
    logic        rf_we;

    assign final_result = in_bus.mfc0 ? cp0_rdata : in_bus.result;

    // an excepting instruction leaves no trace in the register file
    assign rf_we = in_valid & in_bus.gr_we & ~in_bus.ex;

    always_comb begin
        cp0_req.valid    = in_valid;
        cp0_req.mtc0     = in_bus.mtc0;
        cp0_req.eret     = in_bus.eret;
        cp0_req.ex       = in_bus.ex;
        cp0_req.exc_code = in_bus.exc_code;
        cp0_req.rd       = in_bus.cp0_rd;
        cp0_req.sel      = in_bus.cp0_sel;
        cp0_req.bd       = in_bus.bd;
        cp0_req.pc       = in_bus.pc;
        cp0_req.wdata    = in_bus.result;    // rt value for mtc0
        cp0_req.badvaddr = in_bus.result;    // load address on adel
    end

    always_comb begin
        rf_write.we    = rf_we;
        rf_write.waddr = in_bus.dest;
        rf_write.wdata = final_result;
    end

    // redirect the front end on exception or eret
    assign flush    = in_valid & (in_bus.ex | in_bus.eret);
    assign flush_pc = in_bus.ex ? EXC_VECTOR : epc;

    assign debug_wb_pc       = in_bus.pc;
    assign debug_wb_rf_wen   = rf_we;
    assign debug_wb_rf_wnum  = in_bus.dest;
    assign debug_wb_rf_wdata = final_result;

endmodule

`default_nettype wire

//--- verification/retire_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module retire_assertions (
    input wire        clk,
    input wire        reset,
    input wire        flush,
    input wire        debug_wb_rf_wen,
    input wire [4:0]  debug_wb_rf_wnum,
    input wire [4:0]  rf_raddr1,
    input wire [31:0] rf_rdata1
);

    int fail_count = 0;   // failed assertions so far

    // a flush empties both stages, so the next cycle has nothing to flush
    flush_one_cycle: assert property (@(posedge clk) disable iff (reset) flush |=> !flush)
        else begin
            fail_count++;
            $error("flush stayed high for more than one cycle");
        end

    // both stage valids start cleared, so no write for two cycles
    no_write_after_reset: assert property (@(posedge clk) reset |=> !debug_wb_rf_wen [*2])
        else begin
            fail_count++;
            $error("trace write enable high right after reset");
        end

    zero_after_write: assert property (@(posedge clk) disable iff (reset)
        (debug_wb_rf_wen && debug_wb_rf_wnum == 5'd0) |=>
        (rf_raddr1 != 5'd0 || rf_rdata1 == 32'd0))
        else begin
            fail_count++;
            $error("write to register zero changed its value");
        end

endmodule

`default_nettype wire

//--- verification/retire_tb.sv
`timescale 1ns/1ps
`default_nettype none

module retire_tb
    import retire_pkg::*;
();

    localparam int ALU_COUNT   = 200;
    localparam int LOAD_COUNT  = 150;
    localparam int LOOPS       = 10;
    localparam int IRQ_CYCLES  = 80;
    localparam int TEST_CYCLES = ALU_COUNT + LOAD_COUNT + LOOPS * (8 + 9 + 7) + IRQ_CYCLES + 13;
    localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2 + 100;
    localparam logic [31:0] CAUSE_MASK = 32'hbfff_03ff;   // ti and ip7..2 not modeled

    logic        clk;
    logic        reset;
    logic        ex_valid;
    ex_to_ms_t   ex_bus;
    logic [5:0]  ext_int;
    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    logic        flush;
    logic [31:0] flush_pc;
    logic        status_ie;
    logic        status_exl;
    logic [7:0]  status_im;
    logic [7:0]  cause_ip;
    logic        cause_ti;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // reference model state
    logic        m_ms_v;
    logic        m_ws_v;
    ex_to_ms_t   m_ms;
    ex_to_ms_t   m_ws;
    logic [31:0] m_rf [0:31];
    logic [31:0] m_known;          // one bit per register with a known value
    logic        m_ie;
    logic        m_exl;
    logic [7:0]  m_im;
    logic [1:0]  m_ip_sw;
    logic        m_bd;
    logic [4:0]  m_exc;
    logic [31:0] m_epc;
    logic [31:0] m_badv;
    logic [31:0] m_compare;
    logic        ti_cleared;
    logic [5:0]  ext_prev;
    logic [4:0]  last_dest;
    logic        irq_on;
    ex_to_ms_t   ins;
    int          errors = 0;
    int          test_start_errors = 0;
    int          tests_pass = 0;
    int          tests_fail = 0;
    int          cycle_count = 0;

    retire_top DUT (.*);

    bind retire_top retire_assertions u_assertions (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
            errors++;
        end
    endtask

    // extract and extend by the low address bits, little endian lanes
    function automatic logic [31:0] load_value(input ex_to_ms_t i);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(i.load_word >> (8 * i.alu_result[1:0]));
        h = 16'(i.load_word >> (16 * i.alu_result[1]));
        case (i.load_op)
            ld_lb:   return {{24{b[7]}}, b};
            ld_lbu:  return {24'd0, b};
            ld_lh:   return {{16{h[15]}}, h};
            ld_lhu:  return {16'd0, h};
            ld_lw:   return i.load_word;
            default: return i.alu_result;
        endcase
    endfunction

    function automatic logic misaligned(input ex_to_ms_t i);
        case (i.load_op)
            ld_lh, ld_lhu: return i.alu_result[0];
            ld_lw:         return i.alu_result[1:0] != 2'b00;
            default:       return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] cp0_value(input logic [4:0] rd);
        case (rd)
            CP0_BADVADDR: return m_badv;
            CP0_COMPARE:  return m_compare;
            CP0_STATUS:   return {9'd0, 1'b1, 6'd0, m_im, 6'd0, m_exl, m_ie};
            CP0_CAUSE:    return {m_bd, 15'd0, 6'd0, m_ip_sw, 1'b0, m_exc, 2'd0};
            CP0_EPC:      return m_epc;
            default:      return 32'd0;
        endcase
    endfunction

    function automatic ex_to_ms_t alu_ins();
        ex_to_ms_t i;
        i = '0;
        i.pc         = $urandom & 32'hffff_fffc;
        i.alu_result = $urandom;
        i.load_word  = $urandom;
        i.gr_we      = 1'($urandom);
        i.dest       = 5'($urandom);
        i.bd         = 1'($urandom);
        return i;
    endfunction

    function automatic ex_to_ms_t cp0_ins(input logic to_cp0, input logic [4:0] rd,
                                          input logic [31:0] wdata, input logic [4:0] dest);
        ex_to_ms_t i;
        i = alu_ins();
        i.alu_result = wdata;      // rt value for mtc0
        i.mtc0       = to_cp0;
        i.mfc0       = ~to_cp0;
        i.gr_we      = ~to_cp0;
        i.dest       = dest;
        i.cp0_rd     = rd;
        return i;
    endfunction

    // retire the ws slot, then shift the two stage slots
    task automatic model_edge(input logic in_v, input ex_to_ms_t in_ins);
        logic        ex;
        logic [31:0] wdata;
        ex = m_ws.ex_in | misaligned(m_ws);
        wdata = m_ws.mfc0 ? cp0_value(m_ws.cp0_rd) : load_value(m_ws);
        ti_cleared = 1'b0;
        if (m_ws_v && m_ws.gr_we && !ex && m_ws.dest != 5'd0) begin
            m_rf[m_ws.dest] = wdata;
            // a cause read holds unmodeled ti and ip bits
            m_known[m_ws.dest] = !(m_ws.mfc0 && m_ws.cp0_rd == CP0_CAUSE);
            last_dest = m_ws.dest;
        end
        if (m_ws_v && ex) begin
            if (!m_exl) begin              // nested exceptions keep epc and cause
                m_epc = m_ws.bd ? m_ws.pc - 32'd4 : m_ws.pc;
                m_bd  = m_ws.bd;
                m_exc = m_ws.ex_in ? m_ws.exc_code_in : EXC_ADEL;
                if (m_exc == EXC_ADEL) begin
                    m_badv = m_ws.alu_result;
                end
            end
            m_exl = 1'b1;
        end else if (m_ws_v && m_ws.eret) begin
            m_exl = 1'b0;
        end else if (m_ws_v && m_ws.mtc0) begin
            case (m_ws.cp0_rd)
                CP0_STATUS: {m_im, m_exl, m_ie} = {m_ws.alu_result[15:8], m_ws.alu_result[1:0]};
                CP0_CAUSE:  m_ip_sw = m_ws.alu_result[9:8];
                CP0_EPC:    m_epc = m_ws.alu_result;
                CP0_COMPARE: begin
                    m_compare  = m_ws.alu_result;
                    ti_cleared = 1'b1;
                end
                default: ;
            endcase
        end
        if (m_ws_v && (ex || m_ws.eret)) begin
            m_ms_v = 1'b0;                 // the input of this cycle dies too
            m_ws_v = 1'b0;
        end else begin
            m_ws_v = m_ms_v;
            m_ws   = m_ms;
            m_ms_v = in_v;
            m_ms   = in_ins;
        end
    endtask

    task automatic check_cycle();
        logic        ex;
        logic        wen;
        logic [31:0] wdata;
        logic [31:0] mask;
        ex    = m_ws_v & (m_ws.ex_in | misaligned(m_ws));
        wen   = m_ws_v & m_ws.gr_we & ~ex;
        wdata = m_ws.mfc0 ? cp0_value(m_ws.cp0_rd) : load_value(m_ws);
        mask  = (m_ws.mfc0 && m_ws.cp0_rd == CP0_CAUSE) ? CAUSE_MASK : 32'hffff_ffff;
        check_value("debug_wb_rf_wen", wen, debug_wb_rf_wen);
        check_value("flush", ex | (m_ws_v & m_ws.eret), flush);
        if (m_ws_v) begin
            check_value("debug_wb_pc", m_ws.pc, debug_wb_pc);
        end
        if (wen) begin
            check_value("debug_wb_rf_wnum", m_ws.dest, debug_wb_rf_wnum);
            check_value("debug_wb_rf_wdata", wdata & mask, debug_wb_rf_wdata & mask);
        end
        if (ex | (m_ws_v & m_ws.eret)) begin
            check_value("flush_pc", ex ? EXC_VECTOR : m_epc, flush_pc);
        end
        check_value("status_exl", m_exl, status_exl);
        check_value("status_ie", m_ie, status_ie);
        check_value("status_im", m_im, status_im);
        check_value("cause_ip", {ext_prev[5] | cause_ti, ext_prev[4:0], m_ip_sw}, cause_ip);
        if (ti_cleared) begin
            check_value("cause_ti", 32'd0, cause_ti);
        end
        if (m_known[rf_raddr1]) begin
            check_value("rf_rdata1", m_rf[rf_raddr1], rf_rdata1);
        end
        if (m_known[rf_raddr2]) begin
            check_value("rf_rdata2", m_rf[rf_raddr2], rf_rdata2);
        end
    endtask

    task automatic cycle(input logic v, input ex_to_ms_t i);
        @(posedge clk);
        model_edge(ex_valid, ex_bus);
        ext_prev = ext_int;                // what cp0 sampled at this edge
        #1;
        ex_valid  = v;
        ex_bus    = i;
        rf_raddr1 = 5'($urandom);
        rf_raddr2 = last_dest;
        if (irq_on) begin
            ext_int = 6'($urandom);
        end
        #2;
        check_cycle();
    endtask

    task automatic finish_test(input string name);
        repeat (2) cycle(1'b0, '0);
        if (errors == test_start_errors) begin
            tests_pass++;
            $display("%s: ok", name);
        end else begin
            tests_fail++;
            $display("%s: %0d mismatches", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        void'($urandom(32'h855d_a6c2));
        reset     = 1'b1;
        ex_valid  = 1'b0;
        ex_bus    = '0;
        ext_int   = 6'd0;
        rf_raddr1 = 5'd0;
        rf_raddr2 = 5'd0;
        m_ms_v    = 1'b0;
        m_ws_v    = 1'b0;
        m_ms      = '0;
        m_ws      = '0;
        m_rf[0]   = 32'd0;
        m_known   = 32'h1;
        {m_ie, m_exl, m_im, m_ip_sw, m_bd, m_exc} = {1'b0, 1'b1, 8'd0, 2'd0, 1'b0, 5'd0};
        {m_epc, m_badv, m_compare} = '0;
        ti_cleared = 1'b0;
        ext_prev   = 6'd0;
        last_dest  = 5'd0;
        irq_on     = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        repeat (ALU_COUNT) cycle(1'b1, alu_ins());
        finish_test("alu writeback");

        repeat (LOAD_COUNT) begin
            ins = alu_ins();
            ins.load_op = load_op_t'(3'(1 + $urandom_range(4)));
            if (ins.load_op == ld_lw) begin
                ins.alu_result[1:0] = 2'b00;
            end else if (ins.load_op == ld_lh || ins.load_op == ld_lhu) begin
                ins.alu_result[0] = 1'b0;
            end
            cycle(1'b1, ins);
        end
        finish_test("load formatting");

        for (int n = 0; n < LOOPS; n++) begin
            cycle(1'b1, cp0_ins(1'b1, CP0_STATUS, $urandom & 32'h0000_ff01, 5'd0));
            ins = alu_ins();
            ins.load_op = n[0] ? ld_lw : ld_lh;
            ins.alu_result[0] = 1'b1;      // odd address traps both
            ins.gr_we = 1'b1;
            cycle(1'b1, ins);
            repeat (2) cycle(1'b1, alu_ins());
            cycle(1'b1, cp0_ins(1'b0, CP0_EPC, 32'd0, 5'd1));
            cycle(1'b1, cp0_ins(1'b0, CP0_BADVADDR, 32'd0, 5'd2));
            repeat (2) cycle(1'b0, ins);
            check_value("status_exl", 32'd1, status_exl);
        end
        finish_test("misaligned load exception");

        for (int n = 0; n < LOOPS; n++) begin
            cycle(1'b1, cp0_ins(1'b1, CP0_STATUS, $urandom & 32'h0000_ff01, 5'd0));
            cycle(1'b1, cp0_ins(1'b1, CP0_EPC, $urandom & 32'hffff_fffc, 5'd0));
            cycle(1'b1, cp0_ins(1'b0, CP0_STATUS, 32'd0, 5'd3));
            cycle(1'b1, cp0_ins(1'b0, CP0_EPC, 32'd0, 5'd4));
            ins = alu_ins();
            ins.eret  = 1'b1;
            ins.gr_we = 1'b0;
            cycle(1'b1, ins);
            repeat (2) cycle(1'b1, alu_ins());
            repeat (2) cycle(1'b0, ins);
            check_value("status_exl", 32'd0, status_exl);
        end
        finish_test("mtc0 mfc0 eret");

        for (int n = 0; n < LOOPS; n++) begin
            cycle(1'b1, cp0_ins(1'b1, CP0_STATUS, $urandom & 32'h0000_ff01, 5'd0));
            ins = alu_ins();
            ins.ex_in       = 1'b1;
            ins.exc_code_in = EXC_SYS;
            cycle(1'b1, ins);
            repeat (2) cycle(1'b1, alu_ins());
            cycle(1'b1, cp0_ins(1'b0, CP0_CAUSE, 32'd0, 5'd5));
            repeat (2) cycle(1'b0, ins);
        end
        irq_on = 1'b1;
        for (int n = 0; n < IRQ_CYCLES; n++) begin
            if (n % 20 == 0) begin
                cycle(1'b1, cp0_ins(1'b1, CP0_COMPARE, $urandom | 32'h8000_0000, 5'd0));
            end else if (n % 20 == 10) begin
                cycle(1'b1, cp0_ins(1'b1, CP0_CAUSE, $urandom, 5'd0));
            end else begin
                cycle(1'b1, alu_ins());
            end
        end
        irq_on = 1'b0;
        finish_test("syscall and interrupt sampling");

        errors = errors + DUT.u_assertions.fail_count;
        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 tests_pass, tests_fail, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
